/* design/ex_alu.sv */
//////////////////////////////////////////////////
// integer alu
// single cycle add/sub, logic, shifts and compares
// compare result also drives the branch decision
//////////////////////////////////////////////////

module ex_alu
  import ex_pkg::*;
(
  input  alu_op_e operator_i,
  input  word_t   operand_a_i,
  input  word_t   operand_b_i,
  output word_t   result_o,
  output logic    cmp_result_o
);

  logic                sub_en;
  logic                cmp_signed;
  logic [`EX_XLEN:0]   adder_a;
  logic [`EX_XLEN:0]   adder_b;
  logic [`EX_XLEN:0]   adder_res;
  logic                is_lt;
  logic                is_eq;
  logic [4:0]          shamt;

  //////////////////////////////////////////////////
  // shared adder
  //////////////////////////////////////////////////

  // everything except ADD subtracts
  assign sub_en     = (operator_i != ADD);
  // signed compares extend with the sign bit
  assign cmp_signed = (operator_i == SLT) || (operator_i == LT) || (operator_i == GE);

  assign adder_a   = {cmp_signed & operand_a_i[`EX_XLEN-1], operand_a_i};
  assign adder_b   = {cmp_signed & operand_b_i[`EX_XLEN-1], operand_b_i};
  // a + ~b + 1 when subtracting
  assign adder_res = adder_a + (sub_en ? ~adder_b : adder_b) + {{`EX_XLEN{1'b0}}, sub_en};

  // top bit of the extended difference is the borrow
  assign is_lt = adder_res[`EX_XLEN];
  assign is_eq = (operand_a_i == operand_b_i);

  // rv32 shifts use the low five bits only
  assign shamt = operand_b_i[4:0];

  //////////////////////////////////////////////////
  // compare and result select
  //////////////////////////////////////////////////

  always_comb begin
    cmp_result_o = 1'b0;
    case (operator_i)
      EQ:                 cmp_result_o = is_eq;
      NE:                 cmp_result_o = ~is_eq;
      SLT, SLTU, LT, LTU: cmp_result_o = is_lt;
      GE, GEU:            cmp_result_o = ~is_lt;
      default:            cmp_result_o = 1'b0;
    endcase
  end

  always_comb begin
    case (operator_i)
      ADD, SUB: result_o = adder_res[`EX_XLEN-1:0];
      AND:      result_o = operand_a_i & operand_b_i;
      OR:       result_o = operand_a_i | operand_b_i;
      XOR:      result_o = operand_a_i ^ operand_b_i;
      SLL:      result_o = operand_a_i << shamt;
      SRL:      result_o = operand_a_i >> shamt;
      SRA:      result_o = word_t'($signed(operand_a_i) >>> shamt);
      // compares return the flag zero extended
      default:  result_o = {{(`EX_XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

/* design/ex_defs.svh */
//////////////////////////////////////////////////
// execute stage width definitions
// data path, register address and multiplier
// iteration count, fixed for this core
//////////////////////////////////////////////////

`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

//////////////////////////////////////////////////
// data path
//////////////////////////////////////////////////

// integer register width
`define EX_XLEN 32

// register file address, 6 bits to cover gpr + fpr space
`define EX_RADDR_W 6

// one multiplier bit per cycle
`define EX_MUL_STEPS `EX_XLEN

`endif

/* design/ex_mult.sv */
//////////////////////////////////////////////////
// iterative multiplier
// shift-add, one multiplier bit per cycle
// signed high word via magnitudes and final negate
//////////////////////////////////////////////////

`include "ex_defs.svh"

module ex_mult
  import ex_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    enable_i,
  input  mul_op_e operator_i,
  input  word_t   op_a_i,
  input  word_t   op_b_i,
  input  logic    ex_ready_i,
  output word_t   result_o,
  output logic    ready_o,
  output logic    multicycle_o
);

  localparam int CNT_W = $clog2(`EX_MUL_STEPS);

  typedef enum logic [1:0] {S_IDLE, S_ITER, S_DONE} mul_state_e;

  mul_state_e              state_q;
  logic [CNT_W-1:0]        cnt_q;
  logic [2*`EX_XLEN-1:0]   prod_q;
  logic [2*`EX_XLEN-1:0]   prod_fix;
  logic [`EX_XLEN:0]       step_sum;
  word_t                   mcand_q;
  word_t                   mag_a;
  word_t                   mag_b;
  mul_op_e                 op_q;
  logic                    neg_q;
  logic                    is_signed;

  // only MULH treats operands as signed
  assign is_signed = (operator_i == MULH);
  assign mag_a = (is_signed && op_a_i[`EX_XLEN-1]) ? -op_a_i : op_a_i;
  assign mag_b = (is_signed && op_b_i[`EX_XLEN-1]) ? -op_b_i : op_b_i;

  // add multiplicand into the high half when the current bit is set
  assign step_sum = {1'b0, prod_q[2*`EX_XLEN-1:`EX_XLEN]}
                  + (prod_q[0] ? {1'b0, mcand_q} : '0);

  //////////////////////////////////////////////////
  // control fsm
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (enable_i) begin
            state_q <= S_ITER;
            cnt_q   <= '0;
          end
        end
        S_ITER: begin
          // last step moves on, result valid next cycle
          if (cnt_q == CNT_W'(`EX_MUL_STEPS-1)) state_q <= S_DONE;
          else cnt_q <= cnt_q + 1'b1;
        end
        S_DONE: begin
          // hold result until the stage hands it on
          if (ex_ready_i) state_q <= S_IDLE;
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // product register, low half starts as the multiplier
  always_ff @(posedge clk) begin
    if (state_q == S_IDLE && enable_i) begin
      mcand_q <= mag_a;
      prod_q  <= {{`EX_XLEN{1'b0}}, mag_b};
      op_q    <= operator_i;
      neg_q   <= is_signed & (op_a_i[`EX_XLEN-1] ^ op_b_i[`EX_XLEN-1]);
    end else if (state_q == S_ITER) begin
      prod_q <= {step_sum, prod_q[`EX_XLEN-1:1]};
    end
  end

  // sign fix and word select
  assign prod_fix = neg_q ? -prod_q : prod_q;
  assign result_o = (op_q == MUL) ? prod_fix[`EX_XLEN-1:0] : prod_fix[2*`EX_XLEN-1:`EX_XLEN];

  // a new request in idle stalls the stage right away
  assign ready_o      = ((state_q == S_IDLE) && !enable_i) || (state_q == S_DONE);
  assign multicycle_o = (state_q == S_ITER);

endmodule

/* design/ex_pkg.sv */
//////////////////////////////////////////////////
// execute stage package
// operator encodings and data word types
//////////////////////////////////////////////////

`include "ex_defs.svh"

package ex_pkg;

  // one data word and one register write address
  typedef logic [`EX_XLEN-1:0]    word_t;
  typedef logic [`EX_RADDR_W-1:0] raddr_t;

  // alu operators, low group arithmetic/logic, high group compares
  typedef enum logic [3:0] {
    ADD, SUB, AND, OR,
    XOR, SLL, SRL, SRA,
    SLT, SLTU, EQ, NE,
    LT, GE, LTU, GEU
  } alu_op_e;

  // multiplier operators
  // MUL low word, MULH signed high word, MULHU unsigned high word
  typedef enum logic [1:0] {
    MUL,
    MULH,
    MULHU
  } mul_op_e;

endpackage

/* design/ex_stage.sv */
//////////////////////////////////////////////////
// execute stage top
// alu, iterative multiplier, write ports,
// branch outputs and the stage handshake
//////////////////////////////////////////////////

module ex_stage
  import ex_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  // alu
  input  logic    alu_en_i,
  input  alu_op_e alu_operator_i,
  input  word_t   alu_operand_a_i,
  input  word_t   alu_operand_b_i,
  input  word_t   alu_operand_c_i,
  // multiplier
  input  logic    mult_en_i,
  input  mul_op_e mult_operator_i,
  input  word_t   mult_operand_a_i,
  input  word_t   mult_operand_b_i,
  output logic    mult_multicycle_o,
  // csr and lsu
  input  logic    csr_access_i,
  input  word_t   csr_rdata_i,
  input  logic    lsu_en_i,
  input  word_t   lsu_rdata_i,
  input  logic    lsu_ready_ex_i,
  input  logic    lsu_err_i,
  // register destinations from decode
  input  logic    branch_in_ex_i,
  input  logic    regfile_alu_we_i,
  input  raddr_t  regfile_alu_waddr_i,
  input  logic    regfile_we_i,
  input  raddr_t  regfile_waddr_i,
  // forward port and lsu write port
  output logic    regfile_alu_we_fw_o,
  output raddr_t  regfile_alu_waddr_fw_o,
  output word_t   regfile_alu_wdata_fw_o,
  output logic    regfile_we_wb_o,
  output raddr_t  regfile_waddr_wb_o,
  output word_t   regfile_wdata_wb_o,
  // branch resolution
  output word_t   jump_target_o,
  output logic    branch_decision_o,
  // handshake
  input  logic    wb_ready_i,
  output logic    ex_ready_o,
  output logic    ex_valid_o
);

  word_t alu_result;
  word_t mult_result;
  logic  alu_cmp_result;
  logic  mult_ready;
  logic  units_ready;

  //////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////

  assign units_ready = mult_ready & lsu_ready_ex_i & wb_ready_i;

  // valid goes right, ready goes left, no loop between them
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;
  // branches finish here without a wb slot
  assign ex_ready_o = units_ready | branch_in_ex_i;

  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  //////////////////////////////////////////////////
  // units
  //////////////////////////////////////////////////

  ex_alu i_alu (
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  ex_mult i_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_wb_ports i_wb_ports (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .ex_valid_i             (ex_valid_o),
    .wb_ready_i             (wb_ready_i),
    .lsu_err_i              (lsu_err_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o)
  );

endmodule

/* design/ex_wb_ports.sv */
//////////////////////////////////////////////////
// execute stage write ports
// forward port data select and the ex/wb register
// feeding the lsu write port
//////////////////////////////////////////////////

module ex_wb_ports
  import ex_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   ex_valid_i,
  input  logic   wb_ready_i,
  input  logic   lsu_err_i,
  input  logic   regfile_alu_we_i,
  input  raddr_t regfile_alu_waddr_i,
  input  logic   alu_en_i,
  input  logic   mult_en_i,
  input  logic   csr_access_i,
  input  word_t  alu_result_i,
  input  word_t  mult_result_i,
  input  word_t  csr_rdata_i,
  input  logic   regfile_we_i,
  input  raddr_t regfile_waddr_i,
  input  word_t  lsu_rdata_i,
  output logic   regfile_alu_we_fw_o,
  output raddr_t regfile_alu_waddr_fw_o,
  output word_t  regfile_alu_wdata_fw_o,
  output logic   regfile_we_wb_o,
  output raddr_t regfile_waddr_wb_o,
  output word_t  regfile_wdata_wb_o
);

  logic   lsu_we;
  logic   lsu_we_q;
  raddr_t lsu_waddr_q;

  //////////////////////////////////////////////////
  // forward port
  //////////////////////////////////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // csr wins, then mult, then alu
  always_comb begin
    if (csr_access_i)   regfile_alu_wdata_fw_o = csr_rdata_i;
    else if (mult_en_i) regfile_alu_wdata_fw_o = mult_result_i;
    else if (alu_en_i)  regfile_alu_wdata_fw_o = alu_result_i;
    else                regfile_alu_wdata_fw_o = '0;
  end

  //////////////////////////////////////////////////
  // ex/wb register
  //////////////////////////////////////////////////

  // faulting load never writes
  assign lsu_we = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q <= 1'b0;
    end else if (ex_valid_i) begin
      lsu_we_q <= lsu_we;
    end else if (wb_ready_i) begin
      // nothing accepted, flush the slot
      lsu_we_q <= 1'b0;
    end
  end

  // address only matters while the enable is set
  always_ff @(posedge clk) begin
    if (ex_valid_i && lsu_we) lsu_waddr_q <= regfile_waddr_i;
  end

  assign regfile_we_wb_o    = lsu_we_q;
  assign regfile_waddr_wb_o = lsu_waddr_q;
  // load data arrives in the wb cycle itself
  assign regfile_wdata_wb_o = lsu_rdata_i;

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the execute stage testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_ex_stage -f src.f -Mdir obj_dir; then
  echo "verilator build failed"
  exit 1
fi

if ! sim_out=$(./obj_dir/Vtb_ex_stage); then
  echo "$sim_out"
  echo "simulation exited with an error"
  exit 1
fi
echo "$sim_out"

# pass only when the testbench printed its pass line
if grep -q "ALL TESTS PASSED" <<< "$sim_out"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* src.f */
+incdir+design
design/ex_pkg.sv
design/ex_alu.sv
design/ex_mult.sv
design/ex_wb_ports.sv
design/ex_stage.sv
tb/ex_checker.sv
tb/tb_ex_stage.sv

/* tb/ex_checker.sv */
//////////////////////////////////////////////////
// execute stage checker
// reference models for the alu, multiplier timing,
// stage handshake and ex/wb register, compared
// against the dut just before every rising edge
//////////////////////////////////////////////////

`include "ex_defs.svh"

module ex_checker
  import ex_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  // dut inputs
  input  logic    alu_en_i,
  input  alu_op_e alu_operator_i,
  input  word_t   alu_operand_a_i,
  input  word_t   alu_operand_b_i,
  input  word_t   alu_operand_c_i,
  input  logic    mult_en_i,
  input  mul_op_e mult_operator_i,
  input  word_t   mult_operand_a_i,
  input  word_t   mult_operand_b_i,
  input  logic    csr_access_i,
  input  word_t   csr_rdata_i,
  input  logic    lsu_en_i,
  input  word_t   lsu_rdata_i,
  input  logic    lsu_ready_ex_i,
  input  logic    lsu_err_i,
  input  logic    branch_in_ex_i,
  input  logic    regfile_alu_we_i,
  input  raddr_t  regfile_alu_waddr_i,
  input  logic    regfile_we_i,
  input  raddr_t  regfile_waddr_i,
  input  logic    wb_ready_i,
  // dut outputs
  input  logic    mult_multicycle_i,
  input  logic    regfile_alu_we_fw_i,
  input  raddr_t  regfile_alu_waddr_fw_i,
  input  word_t   regfile_alu_wdata_fw_i,
  input  logic    regfile_we_wb_i,
  input  raddr_t  regfile_waddr_wb_i,
  input  word_t   regfile_wdata_wb_i,
  input  word_t   jump_target_i,
  input  logic    branch_decision_i,
  input  logic    ex_ready_i,
  input  logic    ex_valid_i,
  // running totals
  output int      err_cnt_o,
  output int      check_cnt_o
);

  localparam int M_IDLE = 0;
  localparam int M_ITER = 1;
  localparam int M_DONE = 2;

  int     mul_state;
  int     mul_cnt;
  logic   mul_ready;
  logic   exp_valid;
  logic   exp_ready;
  logic   exp_we_wb;
  raddr_t exp_waddr_wb;
  word_t  exp_fw;
  int     errs = 0;
  int     checks = 0;

  assign err_cnt_o   = errs;
  assign check_cnt_o = checks;

  //////////////////////////////////////////////////
  // reference models
  //////////////////////////////////////////////////

  // branch and set-less-than compares
  function automatic logic cmp_model(alu_op_e op, word_t a, word_t b);
    case (op)
      SLT, LT:   return $signed(a) < $signed(b);
      SLTU, LTU: return a < b;
      EQ:        return a == b;
      NE:        return a != b;
      GE:        return $signed(a) >= $signed(b);
      GEU:       return a >= b;
      default:   return 1'b0;
    endcase
  endfunction

  function automatic word_t alu_model(alu_op_e op, word_t a, word_t b);
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLL:     return a << b[4:0];
      SRL:     return a >> b[4:0];
      SRA:     return word_t'($signed(a) >>> b[4:0]);
      // compare flag, zero extended
      default: return word_t'(cmp_model(op, a, b));
    endcase
  endfunction

  // full width products, then pick the word
  function automatic word_t mult_model(mul_op_e op, word_t a, word_t b);
    logic signed [2*`EX_XLEN-1:0] sprod;
    logic        [2*`EX_XLEN-1:0] uprod;
    sprod = $signed({{`EX_XLEN{a[`EX_XLEN-1]}}, a}) * $signed({{`EX_XLEN{b[`EX_XLEN-1]}}, b});
    uprod = {{`EX_XLEN{1'b0}}, a} * {{`EX_XLEN{1'b0}}, b};
    case (op)
      MUL:     return uprod[`EX_XLEN-1:0];
      MULH:    return sprod[2*`EX_XLEN-1:`EX_XLEN];
      default: return uprod[2*`EX_XLEN-1:`EX_XLEN];
    endcase
  endfunction

  task automatic check_bit(input string name, input logic exp_val, input logic act_val);
    checks++;
    if (act_val !== exp_val) begin
      errs++;
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp_val, act_val);
    end
  endtask

  task automatic check_word(input string name, input word_t exp_val, input word_t act_val);
    checks++;
    if (act_val !== exp_val) begin
      errs++;
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp_val, act_val);
    end
  endtask

  //////////////////////////////////////////////////
  // per cycle comparison
  //////////////////////////////////////////////////

  // late in the high-to-low half, inputs and registers are settled
  always begin
    @(negedge clk);
    #4;
    if (!rst_n) begin
      mul_state = M_IDLE;
      mul_cnt   = 0;
      exp_we_wb = 1'b0;
    end else begin
      // multiplier stalls from the first enable until done
      mul_ready = ((mul_state == M_IDLE) && !mult_en_i) || (mul_state == M_DONE);
      exp_valid = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i)
                & mul_ready & lsu_ready_ex_i & wb_ready_i;
      exp_ready = (mul_ready & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
      check_bit("ex_valid_o", exp_valid, ex_valid_i);
      check_bit("ex_ready_o", exp_ready, ex_ready_i);
      check_bit("mult_multicycle_o", mul_state == M_ITER, mult_multicycle_i);

      // forward port
      check_bit("regfile_alu_we_fw_o", regfile_alu_we_i, regfile_alu_we_fw_i);
      check_word("regfile_alu_waddr_fw_o", word_t'(regfile_alu_waddr_i),
                 word_t'(regfile_alu_waddr_fw_i));
      if (csr_access_i) begin
        exp_fw = csr_rdata_i;
      end else if (mult_en_i) begin
        exp_fw = mult_model(mult_operator_i, mult_operand_a_i, mult_operand_b_i);
      end else if (alu_en_i) begin
        exp_fw = alu_model(alu_operator_i, alu_operand_a_i, alu_operand_b_i);
      end else begin
        exp_fw = '0;
      end
      // product only meaningful once the result is valid
      if (exp_valid || !mult_en_i) begin
        check_word("regfile_alu_wdata_fw_o", exp_fw, regfile_alu_wdata_fw_i);
      end

      // branch outputs
      check_word("jump_target_o", alu_operand_c_i, jump_target_i);
      if (alu_operator_i >= SLT) begin
        check_bit("branch_decision_o",
                  cmp_model(alu_operator_i, alu_operand_a_i, alu_operand_b_i),
                  branch_decision_i);
      end

      // ex/wb register, loaded at the previous edge
      check_bit("regfile_we_wb_o", exp_we_wb, regfile_we_wb_i);
      if (exp_we_wb) begin
        check_word("regfile_waddr_wb_o", word_t'(exp_waddr_wb), word_t'(regfile_waddr_wb_i));
      end
      check_word("regfile_wdata_wb_o", lsu_rdata_i, regfile_wdata_wb_i);

      // advance ex/wb model
      if (exp_valid) begin
        exp_we_wb = regfile_we_i & ~lsu_err_i;
        if (exp_we_wb) exp_waddr_wb = regfile_waddr_i;
      end else if (wb_ready_i) begin
        exp_we_wb = 1'b0;
      end

      // advance multiplier timing model
      case (mul_state)
        M_IDLE: begin
          if (mult_en_i) begin
            mul_state = M_ITER;
            mul_cnt   = 0;
          end
        end
        M_ITER: begin
          if (mul_cnt == `EX_MUL_STEPS - 1) mul_state = M_DONE;
          else mul_cnt++;
        end
        default: begin
          if (exp_ready) mul_state = M_IDLE;
        end
      endcase
    end
  end

endmodule

/* tb/tb_ex_stage.sv */
//////////////////////////////////////////////////
// execute stage testbench
// random instruction mix from an xorshift source,
// driven on the falling edge, checked by ex_checker
//////////////////////////////////////////////////

module tb_ex_stage
  import ex_pkg::*;
();

  localparam int NUM_INSTR  = 400;
  localparam int WAIT_LIMIT = 100;

  logic        clk;
  logic        rst_n;
  logic        alu_en_i;
  alu_op_e     alu_operator_i;
  word_t       alu_operand_a_i;
  word_t       alu_operand_b_i;
  word_t       alu_operand_c_i;
  logic        mult_en_i;
  mul_op_e     mult_operator_i;
  word_t       mult_operand_a_i;
  word_t       mult_operand_b_i;
  logic        mult_multicycle_o;
  logic        csr_access_i;
  word_t       csr_rdata_i;
  logic        lsu_en_i;
  word_t       lsu_rdata_i;
  logic        lsu_ready_ex_i;
  logic        lsu_err_i;
  logic        branch_in_ex_i;
  logic        regfile_alu_we_i;
  raddr_t      regfile_alu_waddr_i;
  logic        regfile_we_i;
  raddr_t      regfile_waddr_i;
  logic        regfile_alu_we_fw_o;
  raddr_t      regfile_alu_waddr_fw_o;
  word_t       regfile_alu_wdata_fw_o;
  logic        regfile_we_wb_o;
  raddr_t      regfile_waddr_wb_o;
  word_t       regfile_wdata_wb_o;
  word_t       jump_target_o;
  logic        branch_decision_o;
  logic        wb_ready_i;
  logic        ex_ready_o;
  logic        ex_valid_o;
  int          check_errors;
  int          check_count;
  int          timeout_errors;
  logic [31:0] rng_state;
  logic        stuck;

  ex_stage i_ex_stage (.*);

  ex_checker i_checker (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .alu_operator_i         (alu_operator_i),
    .alu_operand_a_i        (alu_operand_a_i),
    .alu_operand_b_i        (alu_operand_b_i),
    .alu_operand_c_i        (alu_operand_c_i),
    .mult_en_i              (mult_en_i),
    .mult_operator_i        (mult_operator_i),
    .mult_operand_a_i       (mult_operand_a_i),
    .mult_operand_b_i       (mult_operand_b_i),
    .csr_access_i           (csr_access_i),
    .csr_rdata_i            (csr_rdata_i),
    .lsu_en_i               (lsu_en_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_err_i              (lsu_err_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .wb_ready_i             (wb_ready_i),
    .mult_multicycle_i      (mult_multicycle_o),
    .regfile_alu_we_fw_i    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_i (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_i (regfile_alu_wdata_fw_o),
    .regfile_we_wb_i        (regfile_we_wb_o),
    .regfile_waddr_wb_i     (regfile_waddr_wb_o),
    .regfile_wdata_wb_i     (regfile_wdata_wb_o),
    .jump_target_i          (jump_target_o),
    .branch_decision_i      (branch_decision_o),
    .ex_ready_i             (ex_ready_o),
    .ex_valid_i             (ex_valid_o),
    .err_cnt_o              (check_errors),
    .check_cnt_o            (check_count)
  );

  always #5 clk = ~clk;

  //////////////////////////////////////////////////
  // random source and drivers
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic clear_inputs();
    alu_en_i            = 1'b0;
    alu_operator_i      = ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    mult_en_i           = 1'b0;
    mult_operator_i     = MUL;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    csr_access_i        = 1'b0;
    csr_rdata_i         = '0;
    lsu_en_i            = 1'b0;
    lsu_rdata_i         = '0;
    lsu_err_i           = 1'b0;
    branch_in_ex_i      = 1'b0;
    regfile_alu_we_i    = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_we_i        = 1'b0;
    regfile_waddr_i     = '0;
    wb_ready_i          = 1'b1;
    lsu_ready_ex_i      = 1'b1;
  endtask

  // each ready low about one cycle in eight
  task automatic drive_stalls();
    logic [31:0] r;
    r = rand32();
    wb_ready_i     = (r[2:0] != 3'b000);
    lsu_ready_ex_i = (r[5:3] != 3'b000);
  endtask

  // one instruction, held until the stage takes it
  task automatic drive_instr();
    logic [31:0] r;
    int          kind;
    r    = rand32();
    kind = int'(r % 12);
    alu_en_i            = 1'b0;
    mult_en_i           = 1'b0;
    csr_access_i        = 1'b0;
    lsu_en_i            = 1'b0;
    branch_in_ex_i      = 1'b0;
    alu_operator_i      = alu_op_e'(r[7:4]);
    mult_operator_i     = mul_op_e'(r[9:8] % 2'd3);
    alu_operand_a_i     = rand32();
    // equal operands now and then for EQ/NE/GE
    alu_operand_b_i     = r[10] ? alu_operand_a_i : rand32();
    alu_operand_c_i     = rand32();
    mult_operand_a_i    = rand32();
    mult_operand_b_i    = rand32();
    csr_rdata_i         = rand32();
    lsu_rdata_i         = rand32();
    regfile_alu_we_i    = r[14];
    regfile_alu_waddr_i = r[20:15];
    regfile_we_i        = (r[22:21] != 2'b00);
    regfile_waddr_i     = r[28:23];
    lsu_err_i           = (r[30:29] == 2'b00);
    case (kind)
      0, 1, 2, 3: alu_en_i = 1'b1;
      4, 5: begin
        // branch compares only, EQ through GEU
        alu_en_i       = 1'b1;
        branch_in_ex_i = 1'b1;
        alu_operator_i = alu_op_e'(4'd10 + {1'b0, r[13:11] % 3'd6});
      end
      6: mult_en_i = 1'b1;
      7, 8: csr_access_i = 1'b1;
      9, 10: lsu_en_i = 1'b1;
      default: ;
    endcase
  endtask

  // ready sampled mid low phase, the next rising edge consumes
  task automatic wait_accept();
    int cycles;
    cycles = 0;
    #1;
    while (!ex_ready_o && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      drive_stalls();
      #1;
      cycles++;
    end
    if (ex_ready_o) begin
      @(posedge clk);
    end else begin
      $display("ERROR at %0t: ex_ready_o stayed low for %0d cycles, stage is stuck",
               $time, WAIT_LIMIT);
      timeout_errors++;
      stuck = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    rng_state      = 32'hacd2f527;
    timeout_errors = 0;
    stuck          = 1'b0;
    clear_inputs();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int n = 0; n < NUM_INSTR && !stuck; n++) begin
      drive_instr();
      drive_stalls();
      wait_accept();
      @(negedge clk);
    end

    // idle tail lets the last ex/wb write drain
    clear_inputs();
    repeat (3) @(posedge clk);
    #1;
    $display("summary: %0d checks, %0d check errors, %0d timeout errors",
             check_count, check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
